//--- source/bus_pkg.sv
package bus_pkg;

    localparam int bus_addr_w = 6;
    localparam int bus_data_w = 32;

    // word address and data word of the register bus
    typedef logic [bus_addr_w-1:0] bus_addr_t;
    typedef logic [bus_data_w-1:0] bus_data_t;

    // tone generator registers
    localparam bus_addr_t addr_tone_ctrl = 6'd0;
    localparam bus_addr_t addr_tone_freq = 6'd1;
    localparam bus_addr_t addr_tone_dur  = 6'd2;

    // melody player registers, bit 0 of ctrl is start/busy
    localparam bus_addr_t addr_player_ctrl = 6'd4;
    localparam bus_addr_t addr_player_len  = 6'd5;

    // note memory window
    localparam bus_addr_t note_base  = 6'd16;
    localparam int        note_words = 16;
    localparam int        note_addr_w = $clog2(note_words);
    localparam bus_addr_t note_last  = bus_addr_t'(note_base + note_words - 1);

endpackage

//--- source/tone_pkg.sv
package tone_pkg;

    // system clock rate in Hz
    localparam int unsigned clk_freq = 50_000_000;

    localparam int tone_freq_w   = 32;
    localparam int half_period_w = 32;
    localparam int note_dur_w    = 16;

    typedef logic [tone_freq_w-1:0]   tone_freq_t;
    typedef logic [half_period_w-1:0] half_period_t;
    typedef logic [note_dur_w-1:0]    note_dur_t;

    // note word: duration in the low half, frequency in kHz in the high half
    localparam int         note_khz_lsb = 16;
    localparam int         note_khz_w   = 16;
    localparam tone_freq_t freq_unit_hz = 32'd1000;

    typedef enum logic {
        tone_idle,
        tone_run
    } tone_state_t;

    typedef enum logic [2:0] {
        pl_idle,
        pl_fetch,
        pl_write_freq,
        pl_write_dur,
        pl_write_go,
        pl_wait,
        pl_next
    } player_state_t;

endpackage

//--- source/tone_generator.sv
`timescale 1ns/1ns

module tone_generator (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               bus_we,
    input  bus_pkg::bus_addr_t bus_addr,
    input  bus_pkg::bus_data_t bus_wdata,
    output bus_pkg::bus_data_t rdata,
    output logic               buzz
);

    logic                   enable;
    tone_pkg::tone_freq_t   freq;
    tone_pkg::note_dur_t    dur;
    tone_pkg::tone_state_t  state;
    tone_pkg::half_period_t half_period;
    tone_pkg::half_period_t half_cnt;
    tone_pkg::note_dur_t    dur_cnt;

    // cycles per half wave, zero while no frequency is set
    assign half_period = (freq != '0) ?
        tone_pkg::half_period_t'(tone_pkg::clk_freq / freq) : '0;

    always_comb begin
        case (bus_addr)
            bus_pkg::addr_tone_ctrl: rdata = bus_pkg::bus_data_t'(enable);
            bus_pkg::addr_tone_freq: rdata = bus_pkg::bus_data_t'(freq);
            bus_pkg::addr_tone_dur:  rdata = bus_pkg::bus_data_t'(dur);
            default:                 rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable   <= 1'b0;
            freq     <= '0;
            dur      <= '0;
            half_cnt <= '0;
            dur_cnt  <= '0;
            buzz     <= 1'b0;
            state    <= tone_pkg::tone_idle;
        end else if (bus_we) begin
            // a register write wins over the counters in this cycle
            case (bus_addr)
                bus_pkg::addr_tone_ctrl: begin
                    enable <= bus_wdata[0];
                    if (!bus_wdata[0]) begin
                        buzz <= 1'b0;
                    end
                end
                bus_pkg::addr_tone_freq: begin
                    freq <= tone_pkg::tone_freq_t'(bus_wdata);
                end
                bus_pkg::addr_tone_dur: begin
                    dur <= tone_pkg::note_dur_t'(bus_wdata);
                end
                default: begin
                end
            endcase
        end else begin
            case (state)
                tone_pkg::tone_idle: begin
                    if (enable && half_period != '0) begin
                        dur_cnt  <= dur;
                        half_cnt <= half_period;
                        state    <= tone_pkg::tone_run;
                    end
                end
                tone_pkg::tone_run: begin
                    if (!enable) begin
                        // stopped from the bus
                        dur_cnt  <= '0;
                        half_cnt <= '0;
                        buzz     <= 1'b0;
                        state    <= tone_pkg::tone_idle;
                    end else if (dur_cnt > tone_pkg::note_dur_t'(1)) begin
                        if (half_cnt != '0) begin
                            half_cnt <= half_cnt - 1'b1;
                        end else begin
                            half_cnt <= half_period;
                            buzz     <= ~buzz;
                        end
                        dur_cnt <= dur_cnt - 1'b1;
                    end else begin
                        // note is over, enable clears so pollers see the end
                        enable   <= 1'b0;
                        dur_cnt  <= '0;
                        half_cnt <= '0;
                        buzz     <= 1'b0;
                        state    <= tone_pkg::tone_idle;
                    end
                end
                default: begin
                    state <= tone_pkg::tone_idle;
                end
            endcase
        end
    end

endmodule

//--- source/note_memory.sv
`timescale 1ns/1ns

module note_memory (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            we,
    input  logic [bus_pkg::note_addr_w-1:0] addr,
    input  bus_pkg::bus_data_t              wdata,
    output bus_pkg::bus_data_t              rdata
);

    // one note word per entry
    bus_pkg::bus_data_t mem [bus_pkg::note_words];

    assign rdata = mem[addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < bus_pkg::note_words; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

//--- source/melody_player.sv
`timescale 1ns/1ns

module melody_player (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reg_we,
    input  bus_pkg::bus_addr_t reg_addr,
    input  bus_pkg::bus_data_t reg_wdata,
    output bus_pkg::bus_data_t reg_rdata,
    output logic               pl_sel,
    output logic               pl_we,
    output bus_pkg::bus_addr_t pl_addr,
    output bus_pkg::bus_data_t pl_wdata,
    input  logic               pl_grant,
    input  bus_pkg::bus_data_t pl_rdata,
    output logic               busy
);

    tone_pkg::player_state_t           state;
    logic                              start;
    logic [bus_pkg::note_addr_w:0]     len;
    logic [bus_pkg::note_addr_w-1:0]   idx;
    logic [bus_pkg::note_addr_w:0]     idx_next;
    logic                              last_note;
    logic                              xfer;
    bus_pkg::bus_data_t                note_q;
    tone_pkg::tone_freq_t              freq_hz;

    assign busy      = start;
    assign xfer      = pl_sel && pl_grant;
    assign idx_next  = {1'b0, idx} + 1'b1;
    assign last_note = (idx_next >= len) || (&idx);
    assign freq_hz   = tone_pkg::tone_freq_t'(note_q[tone_pkg::note_khz_lsb +: tone_pkg::note_khz_w])
                       * tone_pkg::freq_unit_hz;

    always_comb begin
        case (reg_addr)
            bus_pkg::addr_player_ctrl: reg_rdata = bus_pkg::bus_data_t'(start);
            bus_pkg::addr_player_len:  reg_rdata = bus_pkg::bus_data_t'(len);
            default:                   reg_rdata = '0;
        endcase
    end

    // bus request follows the state, held until granted
    always_comb begin
        pl_sel   = 1'b0;
        pl_we    = 1'b0;
        pl_addr  = '0;
        pl_wdata = '0;
        case (state)
            tone_pkg::pl_fetch: begin
                pl_sel  = 1'b1;
                pl_addr = bus_pkg::note_base + bus_pkg::bus_addr_t'(idx);
            end
            tone_pkg::pl_write_freq: begin
                pl_sel   = 1'b1;
                pl_we    = 1'b1;
                pl_addr  = bus_pkg::addr_tone_freq;
                pl_wdata = bus_pkg::bus_data_t'(freq_hz);
            end
            tone_pkg::pl_write_dur: begin
                pl_sel   = 1'b1;
                pl_we    = 1'b1;
                pl_addr  = bus_pkg::addr_tone_dur;
                pl_wdata = bus_pkg::bus_data_t'(note_q[tone_pkg::note_dur_w-1:0]);
            end
            tone_pkg::pl_write_go: begin
                pl_sel   = 1'b1;
                pl_we    = 1'b1;
                pl_addr  = bus_pkg::addr_tone_ctrl;
                pl_wdata = bus_pkg::bus_data_t'(1);
            end
            tone_pkg::pl_wait: begin
                pl_sel  = 1'b1;
                pl_addr = bus_pkg::addr_tone_ctrl;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == tone_pkg::pl_fetch && xfer) begin
            note_q <= pl_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
            len   <= '0;
            idx   <= '0;
            state <= tone_pkg::pl_idle;
        end else begin
            case (state)
                tone_pkg::pl_idle: begin
                    if (start) begin
                        if (len == '0) begin
                            start <= 1'b0;
                        end else begin
                            idx   <= '0;
                            state <= tone_pkg::pl_fetch;
                        end
                    end
                end
                tone_pkg::pl_fetch: begin
                    if (xfer) begin
                        state <= start ? tone_pkg::pl_write_freq : tone_pkg::pl_idle;
                    end
                end
                tone_pkg::pl_write_freq: begin
                    if (xfer) begin
                        state <= start ? tone_pkg::pl_write_dur : tone_pkg::pl_idle;
                    end
                end
                tone_pkg::pl_write_dur: begin
                    if (xfer) begin
                        state <= start ? tone_pkg::pl_write_go : tone_pkg::pl_idle;
                    end
                end
                tone_pkg::pl_write_go: begin
                    if (xfer) begin
                        state <= start ? tone_pkg::pl_wait : tone_pkg::pl_idle;
                    end
                end
                tone_pkg::pl_wait: begin
                    // poll until the tone generator drops its enable bit
                    if (xfer) begin
                        if (!start) begin
                            state <= tone_pkg::pl_idle;
                        end else if (!pl_rdata[0]) begin
                            state <= tone_pkg::pl_next;
                        end
                    end
                end
                tone_pkg::pl_next: begin
                    if (!start) begin
                        state <= tone_pkg::pl_idle;
                    end else if (last_note) begin
                        start <= 1'b0;
                        state <= tone_pkg::pl_idle;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= tone_pkg::pl_fetch;
                    end
                end
                default: begin
                    state <= tone_pkg::pl_idle;
                end
            endcase
            // register writes come last so a cpu write beats the end of playback
            if (reg_we) begin
                case (reg_addr)
                    bus_pkg::addr_player_ctrl: start <= reg_wdata[0];
                    bus_pkg::addr_player_len:  len <= reg_wdata[bus_pkg::note_addr_w:0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- source/register_bus.sv
`timescale 1ns/1ns

module register_bus (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_sel,
    input  logic               cpu_we,
    input  bus_pkg::bus_addr_t cpu_addr,
    input  bus_pkg::bus_data_t cpu_wdata,
    output bus_pkg::bus_data_t cpu_rdata,
    input  logic               pl_sel,
    input  logic               pl_we,
    input  bus_pkg::bus_addr_t pl_addr,
    input  bus_pkg::bus_data_t pl_wdata,
    output logic               pl_grant,
    output bus_pkg::bus_data_t pl_rdata,
    output logic               bus_we,
    output bus_pkg::bus_addr_t bus_addr,
    output bus_pkg::bus_data_t bus_wdata,
    output logic               tone_we,
    output logic               note_we,
    output logic               player_we,
    input  bus_pkg::bus_data_t tone_rdata,
    input  bus_pkg::bus_data_t note_rdata,
    input  bus_pkg::bus_data_t player_rdata
);

    logic               hit_tone;
    logic               hit_player;
    logic               hit_note;
    bus_pkg::bus_data_t bus_rdata;

    // cpu has fixed priority and the player gets the bus on idle cpu cycles
    assign pl_grant  = !cpu_sel;
    assign bus_we    = cpu_sel ? cpu_we : (pl_sel && pl_we);
    assign bus_addr  = cpu_sel ? cpu_addr : pl_addr;
    assign bus_wdata = cpu_sel ? cpu_wdata : pl_wdata;

    assign hit_tone   = (bus_addr == bus_pkg::addr_tone_ctrl) ||
                        (bus_addr == bus_pkg::addr_tone_freq) ||
                        (bus_addr == bus_pkg::addr_tone_dur);
    assign hit_player = (bus_addr == bus_pkg::addr_player_ctrl) ||
                        (bus_addr == bus_pkg::addr_player_len);
    assign hit_note   = (bus_addr >= bus_pkg::note_base) && (bus_addr <= bus_pkg::note_last);

    assign tone_we   = bus_we && hit_tone;
    assign player_we = bus_we && hit_player;
    assign note_we   = bus_we && hit_note;

    always_comb begin
        if (hit_tone) begin
            bus_rdata = tone_rdata;
        end else if (hit_player) begin
            bus_rdata = player_rdata;
        end else if (hit_note) begin
            bus_rdata = note_rdata;
        end else begin
            bus_rdata = '0;
        end
    end

    assign cpu_rdata = bus_rdata;
    assign pl_rdata  = bus_rdata;

endmodule

//--- source/sound_subsys.sv
`timescale 1ns/1ns

module sound_subsys (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_sel,
    input  logic               cpu_we,
    input  bus_pkg::bus_addr_t cpu_addr,
    input  bus_pkg::bus_data_t cpu_wdata,
    output bus_pkg::bus_data_t cpu_rdata,
    output logic               buzz,
    output logic               player_busy
);

    logic               pl_sel;
    logic               pl_we;
    bus_pkg::bus_addr_t pl_addr;
    bus_pkg::bus_data_t pl_wdata;
    logic               pl_grant;
    bus_pkg::bus_data_t pl_rdata;

    logic               bus_we;
    bus_pkg::bus_addr_t bus_addr;
    bus_pkg::bus_data_t bus_wdata;
    logic               tone_we;
    logic               note_we;
    logic               player_we;
    bus_pkg::bus_data_t tone_rdata;
    bus_pkg::bus_data_t note_rdata;
    bus_pkg::bus_data_t player_rdata;

    register_bus i_register_bus (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_sel      (cpu_sel),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_rdata    (cpu_rdata),
        .pl_sel       (pl_sel),
        .pl_we        (pl_we),
        .pl_addr      (pl_addr),
        .pl_wdata     (pl_wdata),
        .pl_grant     (pl_grant),
        .pl_rdata     (pl_rdata),
        .bus_we       (bus_we),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .tone_we      (tone_we),
        .note_we      (note_we),
        .player_we    (player_we),
        .tone_rdata   (tone_rdata),
        .note_rdata   (note_rdata),
        .player_rdata (player_rdata)
    );

    tone_generator i_tone_generator (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_we    (tone_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .rdata     (tone_rdata),
        .buzz      (buzz)
    );

    note_memory i_note_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (note_we),
        .addr  (bus_addr[bus_pkg::note_addr_w-1:0]),
        .wdata (bus_wdata),
        .rdata (note_rdata)
    );

    melody_player i_melody_player (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (player_we),
        .reg_addr  (bus_addr),
        .reg_wdata (bus_wdata),
        .reg_rdata (player_rdata),
        .pl_sel    (pl_sel),
        .pl_we     (pl_we),
        .pl_addr   (pl_addr),
        .pl_wdata  (pl_wdata),
        .pl_grant  (pl_grant),
        .pl_rdata  (pl_rdata),
        .busy      (player_busy)
    );

endmodule

//--- bench/sound_subsys_assert.sv
`timescale 1ns/1ns

module sound_subsys_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   buzz,
    input logic                   enable,
    input tone_pkg::tone_state_t  state,
    input tone_pkg::tone_freq_t   freq,
    input tone_pkg::half_period_t half_period,
    input logic                   tone_we,
    input bus_pkg::bus_addr_t     bus_addr,
    input bus_pkg::bus_data_t     bus_wdata,
    input logic                   cpu_sel,
    input logic                   pl_sel,
    input logic                   pl_we,
    input bus_pkg::bus_addr_t     pl_addr,
    input bus_pkg::bus_data_t     pl_wdata
);

    logic                   buzz_q;
    logic                   seen;
    logic                   toggle;
    tone_pkg::half_period_t gap;

    // toggle within a running note excludes the forced drop at the end
    assign toggle = enable && (buzz != buzz_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buzz_q <= 1'b0;
            seen   <= 1'b0;
            gap    <= '0;
        end else begin
            buzz_q <= buzz;
            if (toggle) begin
                gap  <= tone_pkg::half_period_t'(1);
                seen <= 1'b1;
            end else begin
                gap <= gap + 1'b1;
                if (!enable) begin
                    seen <= 1'b0;
                end
            end
        end
    end

    a_edge_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (toggle && seen) |-> (gap == half_period + 1'b1))
        else $error("buzz edges not half period + 1 cycles apart");

    a_quiet_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !enable |-> !buzz)
        else $error("buzz high while the tone is disabled");

    a_early_stop: assert property (@(posedge clk) disable iff (!rst_n)
        (tone_we && bus_addr == bus_pkg::addr_tone_ctrl && !bus_wdata[0]) |=> (!buzz && !enable))
        else $error("tone did not stop after a write of 0 to control");

    a_zero_freq: assert property (@(posedge clk) disable iff (!rst_n)
        (enable && freq == '0 && state == tone_pkg::tone_idle) |=>
        (state == tone_pkg::tone_idle && !buzz))
        else $error("tone started with a zero frequency");

    a_reset_state: assert property (@(posedge clk)
        !rst_n |-> (!buzz && !enable && state == tone_pkg::tone_idle))
        else $error("tone generator not idle during reset");

    // a player request seen while the cpu owns the bus must still be there next cycle
    a_cpu_priority: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_sel && pl_sel) |=>
        (pl_sel && $stable(pl_we) && $stable(pl_addr) && $stable(pl_wdata)))
        else $error("player transfer completed while the cpu owned the bus");

endmodule

bind tone_generator sound_subsys_assert i_tone_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .buzz        (buzz),
    .enable      (enable),
    .state       (state),
    .freq        (freq),
    .half_period (half_period),
    .tone_we     (bus_we),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .cpu_sel     (1'b0),
    .pl_sel      (1'b0),
    .pl_we       (1'b0),
    .pl_addr     ('0),
    .pl_wdata    ('0)
);

bind register_bus sound_subsys_assert i_bus_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .buzz        (1'b0),
    .enable      (1'b0),
    .state       (tone_pkg::tone_idle),
    .freq        ('0),
    .half_period ('0),
    .tone_we     (1'b0),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .cpu_sel     (cpu_sel),
    .pl_sel      (pl_sel),
    .pl_we       (pl_we),
    .pl_addr     (pl_addr),
    .pl_wdata    (pl_wdata)
);

//--- bench/sound_subsys_tb.sv
`timescale 1ns/1ns

module sound_subsys_tb;

    logic               clk;
    logic               rst_n;
    logic               cpu_sel;
    logic               cpu_we;
    bus_pkg::bus_addr_t cpu_addr;
    bus_pkg::bus_data_t cpu_wdata;
    bus_pkg::bus_data_t cpu_rdata;
    logic               buzz;
    logic               player_busy;

    logic [31:0] seed;
    int          error_count;
    int          edge_counts[$];
    int          edge_cnt;
    logic        buzz_prev;
    logic        en_prev;
    logic        tone_en;

    sound_subsys i_sound_subsys (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_sel     (cpu_sel),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_rdata   (cpu_rdata),
        .buzz        (buzz),
        .player_busy (player_busy)
    );

    assign tone_en = i_sound_subsys.i_tone_generator.enable;

    always #10 clk = ~clk;

    // per note edge count sampled away from the active edge
    always @(negedge clk) begin
        if (tone_en && buzz != buzz_prev) begin
            edge_cnt = edge_cnt + 1;
        end
        if (en_prev && !tone_en) begin
            edge_counts.push_back(edge_cnt);
            edge_cnt = 0;
        end
        buzz_prev = buzz;
        en_prev   = tone_en;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic fail_with(input string msg);
        error_count = error_count + 1;
        $display("%s at %0t", msg, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            error_count = error_count + 1;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input int addr, input logic [31:0] data);
        cpu_sel   = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = bus_pkg::bus_addr_t'(addr);
        cpu_wdata = data;
        tick();
        cpu_sel = 1'b0;
        cpu_we  = 1'b0;
    endtask

    task automatic bus_read(input int addr, output logic [31:0] data);
        cpu_sel  = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = bus_pkg::bus_addr_t'(addr);
        #10;
        data = cpu_rdata;
        tick();
        cpu_sel = 1'b0;
    endtask

    task automatic read_expect(input int addr, input logic [31:0] exp, input string name);
        logic [31:0] v;
        bus_read(addr, v);
        check_value(name, exp, v);
    endtask

    task automatic wait_enable_clear(input int bound);
        logic [31:0] v;
        int          cycles;
        cycles = 0;
        v      = 32'd1;
        while (v[0]) begin
            if (cycles > bound) begin
                fail_with("timeout waiting for the tone enable bit to clear");
            end
            bus_read(bus_pkg::addr_tone_ctrl, v);
            cycles = cycles + 1;
        end
    endtask

    function automatic int pick_khz(input logic [31:0] r);
        case (r[17:16] % 3)
            0:       return 500;
            1:       return 1000;
            default: return 2000;
        endcase
    endfunction

    task automatic register_access();
        logic [31:0] w;
        // only bit 0 of control is kept and freq is still 0 so no tone starts
        bus_write(bus_pkg::addr_tone_ctrl, 32'hffff_ffff);
        read_expect(bus_pkg::addr_tone_ctrl, 32'd1, "tone_ctrl");
        bus_write(bus_pkg::addr_tone_ctrl, 32'd0);
        seed = next_rand(seed);
        bus_write(bus_pkg::addr_tone_freq, seed);
        read_expect(bus_pkg::addr_tone_freq, seed, "tone_freq");
        seed = next_rand(seed);
        bus_write(bus_pkg::addr_tone_dur, seed);
        read_expect(bus_pkg::addr_tone_dur, {16'd0, seed[15:0]}, "tone_dur");
        bus_write(bus_pkg::addr_player_len, 32'd7);
        read_expect(bus_pkg::addr_player_len, 32'd7, "player_len");
        for (int a = 16; a < 32; a++) begin
            w = next_rand(seed ^ a);
            bus_write(a, w);
        end
        for (int a = 16; a < 32; a++) begin
            read_expect(a, next_rand(seed ^ a), "note_word");
        end
        read_expect(3, 32'd0, "unmapped_3");
        read_expect(6, 32'd0, "unmapped_6");
        read_expect(15, 32'd0, "unmapped_15");
        read_expect(32, 32'd0, "unmapped_32");
        read_expect(63, 32'd0, "unmapped_63");
        bus_write(bus_pkg::addr_tone_freq, 32'd0);
    endtask

    task automatic direct_tone();
        int khz;
        int dur;
        seed = next_rand(seed);
        khz  = pick_khz(seed);
        dur  = 100 + (seed[31:20] % 301);
        bus_write(bus_pkg::addr_tone_freq, khz * 1000);
        bus_write(bus_pkg::addr_tone_dur, dur);
        bus_write(bus_pkg::addr_tone_ctrl, 32'd1);
        wait_enable_clear(dur + 2);
        check_value("buzz", 32'd0, {31'd0, buzz});
    endtask

    task automatic zero_freq_and_stop();
        bus_write(bus_pkg::addr_tone_freq, 32'd0);
        bus_write(bus_pkg::addr_tone_ctrl, 32'd1);
        for (int i = 0; i < 50; i++) begin
            read_expect(bus_pkg::addr_tone_ctrl, 32'd1, "tone_ctrl");
            check_value("buzz", 32'd0, {31'd0, buzz});
        end
        bus_write(bus_pkg::addr_tone_ctrl, 32'd0);
        // early stop in the middle of a long note while buzz is high
        bus_write(bus_pkg::addr_tone_freq, 32'd1_000_000);
        bus_write(bus_pkg::addr_tone_dur, 32'd400);
        bus_write(bus_pkg::addr_tone_ctrl, 32'd1);
        repeat (70) tick();
        bus_write(bus_pkg::addr_tone_ctrl, 32'd0);
        for (int i = 0; i < 20; i++) begin
            check_value("buzz", 32'd0, {31'd0, buzz});
            tick();
        end
        read_expect(bus_pkg::addr_tone_ctrl, 32'd0, "tone_ctrl");
    endtask

    task automatic play_melody(input bit contend);
        int          exp_edges[4];
        int          khz;
        int          dur;
        int          total;
        int          cycles;
        logic [31:0] v;
        total = 0;
        for (int i = 0; i < 4; i++) begin
            seed = next_rand(seed);
            khz  = pick_khz(seed);
            dur  = 100 + (seed[31:20] % 301);
            bus_write(bus_pkg::note_base + i, {khz[15:0], dur[15:0]});
            exp_edges[i] = (dur - 1) / (tone_pkg::clk_freq / (khz * 1000) + 1);
            total = total + dur;
        end
        edge_counts.delete();
        bus_write(bus_pkg::addr_player_len, 32'd4);
        bus_write(bus_pkg::addr_player_ctrl, 32'd1);
        check_value("player_busy", 32'd1, {31'd0, player_busy});
        cycles = 0;
        while (player_busy) begin
            if (cycles > total + 80) begin
                fail_with("timeout waiting for player_busy to fall");
            end
            seed = next_rand(seed);
            if (contend && seed[25:24] == 2'd0) begin
                bus_read(bus_pkg::addr_player_len, v);
                check_value("player_len", 32'd4, v);
            end else begin
                tick();
            end
            cycles = cycles + 1;
        end
        check_value("note_count", 32'd4, edge_counts.size());
        for (int i = 0; i < 4; i++) begin
            check_value("buzz_edges", exp_edges[i], edge_counts[i]);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cpu_sel     = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        seed        = 32'hae366647;
        error_count = 0;
        edge_cnt    = 0;
        buzz_prev   = 1'b0;
        en_prev     = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("buzz", 32'd0, {31'd0, buzz});
        check_value("player_busy", 32'd0, {31'd0, player_busy});
        for (int a = 0; a < 32; a++) begin
            read_expect(a, 32'd0, "reset_read");
        end
        register_access();
        repeat (3) direct_tone();
        zero_freq_and_stop();
        play_melody(1'b0);
        play_melody(1'b1);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- build.f
source/bus_pkg.sv
source/tone_pkg.sv
source/tone_generator.sv
source/note_memory.sv
source/melody_player.sv
source/register_bus.sv
source/sound_subsys.sv
bench/sound_subsys_assert.sv
bench/sound_subsys_tb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module sound_subsys_tb -o sound_subsys_sim

./obj_dir/sound_subsys_sim > sim.log 2>&1 || true
cat sim.log

grep -q "No errors" sim.log
